/* hw/te_trace_pkg.sv */
// ##############################
// trace encoding definitions for the branch trace packet emitter
// field widths, format codes and per-packet request/payload structs
// ##############################
package te_trace_pkg;

    // address width, fixed for rv32
    localparam int unsigned XLEN             = 32;
    localparam int unsigned PRIV_LEN         = 2;
    localparam int unsigned CAUSE_LEN        = 5;
    localparam int unsigned BRANCH_COUNT_LEN = 5;
    localparam int unsigned BRANCH_MAP_LEN   = 31;
    localparam int unsigned IRDEPTH_LEN      = 4;
    // keep-bits count, 0 to 32
    localparam int unsigned KEEP_BITS_LEN    = 6;
    // longest payload is a trap sync with full address and tval
    localparam int unsigned MAX_PACKET_BYTES = 10;
    localparam int unsigned LEN_W            = 4;

    typedef enum logic [1:0] {
        F_OPT_EXT    = 2'd0,
        F_DIFF_DELTA = 2'd1,
        F_ADDR_ONLY  = 2'd2,
        F_SYNC       = 2'd3
    } te_format_e;

    // subformats of F_SYNC
    typedef enum logic [1:0] {
        SF_START   = 2'd0,
        SF_TRAP    = 2'd1,
        SF_CONTEXT = 2'd2,
        SF_SUPPORT = 2'd3
    } te_sync_sf_e;

    typedef enum logic [1:0] {
        PRIV_U    = 2'd0,
        PRIV_S    = 2'd1,
        PRIV_RSVD = 2'd2,
        PRIV_M    = 2'd3
    } te_priv_e;

    typedef enum logic [1:0] {
        QS_NO_CHANGE  = 2'd0,
        QS_ENDED_REP  = 2'd1,
        QS_TRACE_LOST = 2'd2,
        QS_ENDED_NTR  = 2'd3
    } te_qual_status_e;

    // instruction trace options, one bit per mode
    typedef enum logic [2:0] {
        IOPT_DELTA        = 3'b000,
        IOPT_FULL_ADDR    = 3'b001,
        IOPT_IMPLICIT_RET = 3'b010,
        IOPT_IMPLICIT_EXC = 3'b100
    } te_ioptions_e;

    // one trace request, cause/tval/interrupt already muxed upstream
    typedef struct packed {
        te_format_e                    format;
        te_sync_sf_e                   subformat;
        logic [CAUSE_LEN-1:0]          cause;
        logic [XLEN-1:0]               tval;
        logic                          interrupt;
        logic                          branch;
        logic                          branch_taken;
        te_priv_e                      priv;
        logic [XLEN-1:0]               iaddr;
        logic                          thaddr;
        // trap vector, word aligned
        logic [XLEN-1:2]               tvec;
        logic [XLEN-1:0]               epc;
        logic                          ienable;
        logic                          encoder_mode;
        te_qual_status_e               qual_status;
        te_ioptions_e                  ioptions;
        logic                          lc_updiscon;
        logic [BRANCH_COUNT_LEN-1:0]   branches;
        logic [BRANCH_MAP_LEN-1:0]     branch_map;
        logic [KEEP_BITS_LEN-1:0]      keep_bits;
    } te_req_t;

    // payload bits lsb first, length in bytes
    typedef struct packed {
        logic [MAX_PACKET_BYTES*8-1:0] data;
        logic [LEN_W-1:0]              len;
    } te_payload_t;

endpackage

/* hw/te_bus_pkg.sv */
// ##############################
// wishbone classic structs for the byte-wide trace sink bus
// ##############################
package te_bus_pkg;

    // master to sink, single byte lane
    typedef struct packed {
        logic                           cyc;
        logic                           stb;
        logic                           we;
        // byte index inside the packet
        logic [te_trace_pkg::LEN_W-1:0] adr;
        logic [7:0]                     dat;
    } te_wb_m2s_t;

    // sink to master
    typedef struct packed {
        logic ack;
    } te_wb_s2m_t;

endpackage

/* hw/te_payload_builder.sv */
// ##############################
// payload builder, packs the fields of each trace format
// lsb first and holds the latest emitted address
// ##############################
`timescale 1ns/10ps

module te_payload_builder (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  te_trace_pkg::te_req_t     req_i,
    input  logic                      accept_i,
    output te_trace_pkg::te_payload_t payload_o
);

    localparam int unsigned XLEN   = te_trace_pkg::XLEN;
    localparam int unsigned PAY_W  = te_trace_pkg::MAX_PACKET_BYTES * 8;
    localparam int unsigned POS_W  = $clog2(PAY_W + 1);
    // notify, updiscon, irreport, irdepth
    localparam int unsigned TAIL_W = 3 + te_trace_pkg::IRDEPTH_LEN;

    logic                                 branch_bit;
    logic [XLEN-1:0]                      trap_addr;
    logic [XLEN-1:0]                      diff_addr;
    logic [XLEN-1:0]                      latest_q;
    logic [2:0]                           kb;
    logic [5:0]                           map_w;
    logic                                 notify;
    logic                                 updiscon;
    logic                                 irreport;
    logic [te_trace_pkg::IRDEPTH_LEN-1:0] irdepth;
    logic                                 add_tail;
    logic                                 upd_latest;
    logic [PAY_W-1:0]                     bits;
    logic [POS_W-1:0]                     used;

    // low width bits of val, moved up to bit position at
    function automatic logic [PAY_W-1:0] place(
        input logic [XLEN-1:0]  val,
        input int unsigned      width,
        input logic [POS_W-1:0] at
    );
        logic [XLEN-1:0] mask;
        mask = (width >= XLEN) ? '1 : ((XLEN'(1) << width) - XLEN'(1));
        return PAY_W'(val & mask) << at;
    endfunction

    // 0 when the branch was taken
    assign branch_bit = ~(req_i.branch & req_i.branch_taken);
    assign trap_addr  = req_i.thaddr ? {req_i.tvec, 2'b00} : req_i.epc;
    assign diff_addr  = req_i.iaddr - latest_q;

    // kept address bytes, ceil(keep_bits/8), saturates at 4
    assign kb = (req_i.keep_bits >= 6'd32) ? 3'd4 : 3'((req_i.keep_bits + 6'd7) >> 3);

    // tail flags, no trigger unit and no implicit return here
    assign notify   = req_i.iaddr[XLEN-1];
    assign updiscon = notify ^ req_i.lc_updiscon;
    assign irreport = updiscon;
    assign irdepth  = {te_trace_pkg::IRDEPTH_LEN{updiscon}};

    // branch map truncated to the next supported width
    always_comb begin
        if (req_i.branches == '0) begin
            map_w = 6'd0;
        end else if (req_i.branches == 5'd1) begin
            map_w = 6'd1;
        end else if (req_i.branches <= 5'd9) begin
            map_w = 6'd9;
        end else if (req_i.branches <= 5'd17) begin
            map_w = 6'd17;
        end else if (req_i.branches <= 5'd25) begin
            map_w = 6'd25;
        end else begin
            map_w = 6'd31;
        end
    end

    always_comb begin
        bits       = '0;
        used       = '0;
        add_tail   = 1'b0;
        upd_latest = 1'b0;

        // format leads every packet
        bits = bits | place(XLEN'(req_i.format), 2, used);
        used = used + POS_W'(2);

        case (req_i.format)
            te_trace_pkg::F_SYNC: begin
                // context subformat is not supported, format bits only
                if (req_i.subformat != te_trace_pkg::SF_CONTEXT) begin
                    bits = bits | place(XLEN'(req_i.subformat), 2, used);
                    used = used + POS_W'(2);
                end
                case (req_i.subformat)
                    te_trace_pkg::SF_START: begin
                        upd_latest = 1'b1;
                        bits = bits | place(XLEN'({req_i.priv, branch_bit}), 3, used);
                        used = used + POS_W'(3);
                        // full iaddr, compressed by byte
                        bits = bits | place(req_i.iaddr, 8 * kb, used);
                        used = used + POS_W'(8 * kb);
                    end
                    te_trace_pkg::SF_TRAP: begin
                        upd_latest = 1'b1;
                        bits = bits | place(XLEN'({req_i.thaddr, req_i.interrupt, req_i.cause,
                                                   req_i.priv, branch_bit}), 10, used);
                        used = used + POS_W'(10);
                        bits = bits | place(trap_addr, 8 * kb, used);
                        used = used + POS_W'(8 * kb);
                        // tval always goes in full
                        bits = bits | place(req_i.tval, XLEN, used);
                        used = used + POS_W'(XLEN);
                    end
                    te_trace_pkg::SF_SUPPORT: begin
                        bits = bits | place(XLEN'({req_i.ioptions, req_i.qual_status,
                                                   req_i.encoder_mode, req_i.ienable}), 7, used);
                        used = used + POS_W'(7);
                    end
                    default: begin
                    end
                endcase
            end
            te_trace_pkg::F_ADDR_ONLY: begin
                upd_latest = 1'b1;
                add_tail   = 1'b1;
            end
            te_trace_pkg::F_DIFF_DELTA: begin
                upd_latest = 1'b1;
                bits = bits | place(XLEN'(req_i.branches), 5, used);
                used = used + POS_W'(5);
                bits = bits | place(XLEN'(req_i.branch_map), map_w, used);
                used = used + POS_W'(map_w);
                // full map, address not needed
                add_tail = (req_i.branches < 5'd31);
            end
            // opt ext not supported
            default: begin
            end
        endcase

        // differential address and flags
        if (add_tail) begin
            bits = bits | place(diff_addr, 8 * kb, used);
            used = used + POS_W'(8 * kb);
            bits = bits | place(XLEN'({irdepth, irreport, updiscon, notify}), TAIL_W, used);
            used = used + POS_W'(TAIL_W);
        end

        payload_o.data = bits;
        payload_o.len  = te_trace_pkg::LEN_W'((used + 7) / 8);
    end

    // latest address moves only on an accepted address-carrying packet
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            latest_q <= '0;
        end else if (accept_i && upd_latest) begin
            latest_q <= req_i.iaddr;
        end
    end

endmodule

/* hw/te_emit_fsm.sv */
// ##############################
// emitter fsm, takes one request
// and runs the bus until the last ack
// ##############################
`timescale 1ns/10ps

module te_emit_fsm (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  logic                   last_i,
    input  te_bus_pkg::te_wb_s2m_t wb_i,
    output logic                   accept_o,
    output logic                   advance_o,
    output logic                   cyc_o
);

    typedef enum logic {
        IDLE = 1'b0,
        SEND = 1'b1
    } state_e;

    state_e state_q;
    state_e state_d;

    // ready only between packets
    assign req_ready_o = (state_q == IDLE);
    assign accept_o    = req_valid_i & req_ready_o;
    // one byte done per ack
    assign advance_o   = (state_q == SEND) & wb_i.ack;
    // cyc held for the whole packet
    assign cyc_o       = (state_q == SEND);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept_o) begin
                    state_d = SEND;
                end
            end
            SEND: begin
                // ack of the last byte ends the packet
                if (advance_o && last_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

/* hw/te_byte_counter.sv */
// ##############################
// byte index and last-byte flag
// of the packet on the bus
// ##############################
`timescale 1ns/10ps

module te_byte_counter #(
    parameter int unsigned DEPTH_BYTES = te_trace_pkg::MAX_PACKET_BYTES
) (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           load_i,
    input  logic                           advance_i,
    input  logic [te_trace_pkg::LEN_W-1:0] len_i,
    output logic [te_trace_pkg::LEN_W-1:0] idx_o,
    output logic                           last_o
);

    localparam int unsigned LEN_W = te_trace_pkg::LEN_W;

    logic [LEN_W-1:0] idx_q;
    logic [LEN_W-1:0] len_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            idx_q <= '0;
            len_q <= '0;
        end else if (load_i) begin
            idx_q <= '0;
            // never count past the packet buffer
            len_q <= (len_i > DEPTH_BYTES) ? LEN_W'(DEPTH_BYTES) : len_i;
        end else if (advance_i) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    assign idx_o  = idx_q;
    assign last_o = (idx_q == len_q - 1'b1);

endmodule

/* hw/te_byte_shifter.sv */
// ##############################
// packet buffer, one payload byte
// presented at a time
// ##############################
`timescale 1ns/10ps

module te_byte_shifter #(
    parameter int unsigned DEPTH_BYTES = te_trace_pkg::MAX_PACKET_BYTES
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      load_i,
    input  logic                      advance_i,
    input  te_trace_pkg::te_payload_t payload_i,
    output logic [7:0]                byte_o
);

    localparam int unsigned BUF_W = DEPTH_BYTES * 8;

    logic [BUF_W-1:0] buf_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            buf_q <= '0;
        end else if (load_i) begin
            // whole payload in at accept
            buf_q <= BUF_W'(payload_i.data);
        end else if (advance_i) begin
            // next byte slides into the low lane
            buf_q <= {8'h00, buf_q[BUF_W-1:8]};
        end
    end

    assign byte_o = buf_q[7:0];

endmodule

/* hw/te_packet_emitter.sv */
// ##############################
// branch trace packet emitter, one request
// in, packet out as wishbone byte writes
// ##############################
`timescale 1ns/10ps

module te_packet_emitter #(
    parameter int unsigned DEPTH_BYTES = te_trace_pkg::MAX_PACKET_BYTES
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  te_trace_pkg::te_req_t  req_i,
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    output logic                   branch_map_flush_o,
    output te_bus_pkg::te_wb_m2s_t wb_o,
    input  te_bus_pkg::te_wb_s2m_t wb_i
);

    te_trace_pkg::te_payload_t      payload;
    logic                           accept;
    logic                           advance;
    logic                           cyc;
    logic                           last;
    logic [te_trace_pkg::LEN_W-1:0] idx;
    logic [7:0]                     tx_byte;

    te_payload_builder u_builder (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (req_i),
        .accept_i (accept),
        .payload_o(payload)
    );

    te_emit_fsm u_fsm (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .req_valid_i(req_valid_i),
        .req_ready_o(req_ready_o),
        .last_i     (last),
        .wb_i       (wb_i),
        .accept_o   (accept),
        .advance_o  (advance),
        .cyc_o      (cyc)
    );

    te_byte_counter #(
        .DEPTH_BYTES(DEPTH_BYTES)
    ) u_counter (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .load_i   (accept),
        .advance_i(advance),
        .len_i    (payload.len),
        .idx_o    (idx),
        .last_o   (last)
    );

    te_byte_shifter #(
        .DEPTH_BYTES(DEPTH_BYTES)
    ) u_shifter (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .load_i   (accept),
        .advance_i(advance),
        .payload_i(payload),
        .byte_o   (tx_byte)
    );

    // map is consumed in the accept cycle
    assign branch_map_flush_o = accept;

    // single writes, stb follows cyc
    always_comb begin
        wb_o.cyc = cyc;
        wb_o.stb = cyc;
        wb_o.we  = 1'b1;
        wb_o.adr = idx;
        wb_o.dat = tx_byte;
    end

endmodule

/* bench/te_packet_emitter_checker.sv */
// ##############################
// wishbone and request handshake assertions
// bound into the packet emitter
// ##############################
`timescale 1ns/10ps

module te_packet_emitter_checker (
    input logic                   clk_i,
    input logic                   rst_ni,
    input logic                   req_ready_o,
    input te_bus_pkg::te_wb_m2s_t wb_o,
    input te_bus_pkg::te_wb_s2m_t wb_i
);

    // failures so far, read by the testbench at the end
    int unsigned fail_cnt = 0;

    // strobe only inside a bus cycle
    stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_o.stb |-> wb_o.cyc)
        else begin
            $error("stb high without cyc");
            fail_cnt++;
        end

    // byte and index held until the sink acks
    hold_until_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wb_o.stb && !wb_i.ack) |=> ($stable(wb_o.dat) && $stable(wb_o.adr)))
        else begin
            $error("dat or adr changed while waiting for ack");
            fail_cnt++;
        end

    // one packet in flight
    busy_not_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_o.cyc |-> !req_ready_o)
        else begin
            $error("req_ready_o high during a bus cycle");
            fail_cnt++;
        end

    first_adr_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(wb_o.cyc) |-> (wb_o.adr == '0))
        else begin
            $error("first byte of a packet not at adr 0");
            fail_cnt++;
        end

endmodule

bind te_packet_emitter te_packet_emitter_checker u_checker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_ready_o(req_ready_o),
    .wb_o       (wb_o),
    .wb_i       (wb_i)
);

/* bench/te_packet_emitter_tb.sv */
// ##############################
// testbench for the trace packet emitter, table driven
// with a bit-queue reference model and a random-delay sink
// ##############################
`timescale 1ns/10ps

module te_packet_emitter_tb;

    localparam int unsigned NUM_ENTRIES = 18;
    // one packet at worst is 10 bytes with 3 wait cycles each, plus gaps
    localparam int unsigned CYCLE_LIMIT =
        NUM_ENTRIES * (te_trace_pkg::MAX_PACKET_BYTES * 4 + 8);

    // one stimulus row, fields beyond these are fixed in make_request
    typedef struct packed {
        logic [1:0]  fmt;
        logic [1:0]  sf;
        logic [31:0] addr;
        logic [5:0]  keep;
        logic [4:0]  branches;
        // branch_taken, thaddr and lc_updiscon
        logic        flag;
        logic [2:0]  gap;
        logic [3:0]  bytes;
    } entry_t;

    logic                      clk_i = 1'b0;
    logic                      rst_ni;
    te_trace_pkg::te_req_t     req_i;
    logic                      req_valid_i;
    logic                      req_ready_o;
    logic                      branch_map_flush_o;
    te_bus_pkg::te_wb_m2s_t    wb_o;
    te_bus_pkg::te_wb_s2m_t    wb_i;

    entry_t      tbl [NUM_ENTRIES];
    logic        bit_q [$];
    logic [7:0]  exp_q [$];
    logic [31:0] ref_latest;
    logic [15:0] lfsr_q;
    int unsigned errors;
    int unsigned total_bytes;
    int unsigned cycle_cnt = 0;

    te_packet_emitter #(
        .DEPTH_BYTES(te_trace_pkg::MAX_PACKET_BYTES)
    ) u_te_packet_emitter (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .req_i             (req_i),
        .req_valid_i       (req_valid_i),
        .req_ready_o       (req_ready_o),
        .branch_map_flush_o(branch_map_flush_o),
        .wb_o              (wb_o),
        .wb_i              (wb_i)
    );

    // 4 ns period
    always #2 clk_i = ~clk_i;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // two fresh bits give 0..3 wait cycles
    task automatic draw_delay(output int d);
        lfsr_q = lfsr_next(lfsr_q);
        d = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
        d = d * 2 + lfsr_q[0];
    endtask

    function automatic te_trace_pkg::te_req_t make_request(input entry_t e);
        te_trace_pkg::te_req_t r;
        r              = '0;
        r.format       = te_trace_pkg::te_format_e'(e.fmt);
        r.subformat    = te_trace_pkg::te_sync_sf_e'(e.sf);
        r.iaddr        = e.addr;
        r.keep_bits    = e.keep;
        r.branches     = e.branches;
        r.branch_map   = ~e.addr[30:0];
        r.cause        = 5'h0b;
        r.tval         = 32'hdead_beef;
        r.interrupt    = 1'b1;
        r.branch       = 1'b1;
        r.branch_taken = e.flag;
        r.priv         = te_trace_pkg::PRIV_M;
        r.thaddr       = e.flag;
        r.tvec         = 30'h2000_0010;
        r.epc          = e.addr ^ 32'h0000_0f10;
        r.ienable      = 1'b1;
        r.qual_status  = te_trace_pkg::QS_ENDED_REP;
        r.ioptions     = te_trace_pkg::IOPT_FULL_ADDR;
        r.lc_updiscon  = e.flag;
        return r;
    endfunction

    // append width bits of val, lsb first
    task automatic push_bits(input logic [31:0] val, input int width);
        for (int i = 0; i < width; i++) begin
            bit_q.push_back(val[i]);
        end
    endtask

    // diff address, notify, updiscon, irreport, irdepth
    task automatic push_tail(input te_trace_pkg::te_req_t r, input int kb);
        logic upd;
        upd = r.iaddr[31] ^ r.lc_updiscon;
        push_bits(r.iaddr - ref_latest, 8 * kb);
        push_bits(r.iaddr[31], 1);
        // updiscon, then irreport which mirrors it
        push_bits(upd, 1);
        push_bits(upd, 1);
        push_bits({4{upd}}, 4);
    endtask

    // reference packing, fills exp_q and moves ref_latest
    task automatic build_expected(input te_trace_pkg::te_req_t r);
        int         kb;
        int         map_w;
        logic       upd_latest;
        logic [7:0] b;
        bit_q.delete();
        exp_q.delete();
        upd_latest = 1'b0;
        kb = (r.keep_bits >= 32) ? 4 : (r.keep_bits + 7) / 8;
        if (r.branches == 0) begin
            map_w = 0;
        end else if (r.branches == 1) begin
            map_w = 1;
        end else begin
            map_w = (r.branches <= 9) ? 9 : (r.branches <= 17) ? 17 :
                    (r.branches <= 25) ? 25 : 31;
        end
        push_bits(r.format, 2);
        if (r.format == te_trace_pkg::F_SYNC && r.subformat != te_trace_pkg::SF_CONTEXT) begin
            push_bits(r.subformat, 2);
            push_bits(~(r.branch & r.branch_taken),
                      r.subformat == te_trace_pkg::SF_SUPPORT ? 0 : 1);
            if (r.subformat == te_trace_pkg::SF_START) begin
                push_bits(r.priv, 2);
                push_bits(r.iaddr, 8 * kb);
                upd_latest = 1'b1;
            end else if (r.subformat == te_trace_pkg::SF_TRAP) begin
                push_bits(r.priv, 2);
                push_bits(r.cause, 5);
                push_bits({r.thaddr, r.interrupt}, 2);
                push_bits(r.thaddr ? {r.tvec, 2'b00} : r.epc, 8 * kb);
                push_bits(r.tval, 32);
                upd_latest = 1'b1;
            end else begin
                push_bits({r.ioptions, r.qual_status, r.encoder_mode, r.ienable}, 7);
            end
        end else if (r.format == te_trace_pkg::F_ADDR_ONLY) begin
            push_tail(r, kb);
            upd_latest = 1'b1;
        end else if (r.format == te_trace_pkg::F_DIFF_DELTA) begin
            push_bits(r.branches, 5);
            push_bits({1'b0, r.branch_map}, map_w);
            if (r.branches < 31) begin
                push_tail(r, kb);
            end
            upd_latest = 1'b1;
        end
        for (int i = 0; i < bit_q.size(); i += 8) begin
            b = '0;
            for (int j = 0; j < 8 && i + j < bit_q.size(); j++) begin
                b[j] = bit_q[i + j];
            end
            exp_q.push_back(b);
        end
        if (upd_latest) begin
            ref_latest = r.iaddr;
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp,
                              input int n, input int k);
        if (got !== exp) begin
            errors++;
            $display("FAIL wb_o.dat entry %0d byte %0d: got 0x%02h, expected 0x%02h",
                     n, k, got, exp);
        end
    endtask

    task automatic check_adr(input logic [te_trace_pkg::LEN_W-1:0] got,
                             input logic [te_trace_pkg::LEN_W-1:0] exp, input int n);
        if (got !== exp) begin
            errors++;
            $display("FAIL wb_o.adr entry %0d: got 0x%0h, expected 0x%0h", n, got, exp);
        end
    endtask

    task automatic check_flush(input logic got, input logic exp, input int n);
        if (got !== exp) begin
            errors++;
            $display("FAIL branch_map_flush_o entry %0d: got 0x%0h, expected 0x%0h",
                     n, got, exp);
        end
    endtask

    task automatic check_we(input logic got, input logic exp, input int n);
        if (got !== exp) begin
            errors++;
            $display("FAIL wb_o.we entry %0d: got 0x%0h, expected 0x%0h", n, got, exp);
        end
    endtask

    task automatic print_summary();
        $display("summary: %0d bytes, %0d check errors, %0d assertion failures",
                 total_bytes, errors, u_te_packet_emitter.u_checker.fail_cnt);
    endtask

    task automatic load_table();
        // fmt, sf, addr, keep, branches, flag, gap, bytes
        tbl[0]  = '{2'd2, 2'd0, 32'h0000_1240, 6'd16, 5'd0,  1'b0, 3'd1, 4'd4};
        tbl[1]  = '{2'd3, 2'd0, 32'h8000_1000, 6'd32, 5'd0,  1'b0, 3'd0, 4'd5};
        tbl[2]  = '{2'd2, 2'd0, 32'h8000_1058, 6'd7,  5'd0,  1'b1, 3'd2, 4'd3};
        tbl[3]  = '{2'd2, 2'd0, 32'h0000_2000, 6'd20, 5'd0,  1'b1, 3'd0, 4'd5};
        tbl[4]  = '{2'd3, 2'd1, 32'h0000_3000, 6'd0,  5'd0,  1'b1, 3'd3, 4'd6};
        tbl[5]  = '{2'd3, 2'd1, 32'h0000_3100, 6'd32, 5'd0,  1'b0, 3'd1, 4'd10};
        tbl[6]  = '{2'd3, 2'd1, 32'h8000_4000, 6'd20, 5'd0,  1'b1, 3'd0, 4'd9};
        tbl[7]  = '{2'd3, 2'd3, 32'h0000_0000, 6'd0,  5'd0,  1'b0, 3'd2, 4'd2};
        tbl[8]  = '{2'd3, 2'd0, 32'h8000_5000, 6'd7,  5'd0,  1'b1, 3'd0, 4'd2};
        tbl[9]  = '{2'd3, 2'd0, 32'h8000_5100, 6'd0,  5'd0,  1'b0, 3'd1, 4'd1};
        tbl[10] = '{2'd1, 2'd0, 32'h8000_5200, 6'd20, 5'd0,  1'b0, 3'd2, 4'd5};
        tbl[11] = '{2'd1, 2'd0, 32'h0000_6000, 6'd7,  5'd1,  1'b1, 3'd0, 4'd3};
        tbl[12] = '{2'd1, 2'd0, 32'h8000_6040, 6'd0,  5'd9,  1'b0, 3'd3, 4'd3};
        tbl[13] = '{2'd1, 2'd0, 32'h8000_7000, 6'd32, 5'd20, 1'b1, 3'd1, 4'd9};
        tbl[14] = '{2'd1, 2'd0, 32'h0000_7100, 6'd32, 5'd31, 1'b0, 3'd0, 4'd5};
        tbl[15] = '{2'd2, 2'd0, 32'h8000_7200, 6'd32, 5'd0,  1'b0, 3'd2, 4'd6};
        tbl[16] = '{2'd3, 2'd0, 32'h0000_8120, 6'd20, 5'd0,  1'b1, 3'd1, 4'd4};
        tbl[17] = '{2'd3, 2'd1, 32'h8000_8200, 6'd7,  5'd0,  1'b0, 3'd0, 4'd7};
    endtask

    // run limit
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            print_summary();
            $display("Checks failed");
            $finish;
        end
    end

    initial begin : stimulus
        te_trace_pkg::te_req_t r;
        int   delay;
        logic lost;
        rst_ni      = 1'b0;
        req_i       = '0;
        req_valid_i = 1'b0;
        wb_i        = '0;
        errors      = 0;
        total_bytes = 0;
        ref_latest  = '0;
        lfsr_q      = 16'd34727;
        load_table();
        repeat (2) @(negedge clk_i);
        rst_ni = 1'b1;

        for (int n = 0; n < NUM_ENTRIES; n++) begin
            r = make_request(tbl[n]);
            build_expected(r);
            if (exp_q.size() != tbl[n].bytes) begin
                errors++;
                $display("entry %0d: reference gives %0d bytes, table says %0d",
                         n, exp_q.size(), tbl[n].bytes);
            end
            repeat (tbl[n].gap) begin
                @(negedge clk_i);
                req_valid_i = 1'b0;
                #1;
                check_flush(branch_map_flush_o, 1'b0, n);
            end

            // offer, taken at the next rising edge
            @(negedge clk_i);
            req_i       = r;
            req_valid_i = 1'b1;
            #1;
            if (!req_ready_o) begin
                errors++;
                $display("entry %0d: req_ready_o low when the emitter should be idle", n);
            end
            check_flush(branch_map_flush_o, 1'b1, n);

            // valid stays up, so any mid-packet acceptance shows as a flush
            lost = 1'b0;
            for (int k = 0; k < exp_q.size() && !lost; k++) begin
                draw_delay(delay);
                for (int w = 0; w <= delay && !lost; w++) begin
                    @(negedge clk_i);
                    wb_i.ack = (w == delay);
                    #1;
                    if (!wb_o.stb) begin
                        errors++;
                        lost = 1'b1;
                        $display("entry %0d: byte %0d missing, stb is low", n, k);
                    end
                    check_flush(branch_map_flush_o, 1'b0, n);
                    if (req_ready_o) begin
                        errors++;
                        $display("entry %0d: req_ready_o high in the middle of a packet", n);
                    end
                end
                if (!lost) begin
                    check_we(wb_o.we, 1'b1, n);
                    check_adr(wb_o.adr, te_trace_pkg::LEN_W'(k), n);
                    check_byte(wb_o.dat, exp_q[k], n, k);
                    total_bytes++;
                end
            end

            @(negedge clk_i);
            req_valid_i = 1'b0;
            wb_i.ack    = 1'b0;
            #1;
            if (wb_o.cyc) begin
                errors++;
                $display("entry %0d: extra byte, cyc still high after %0d bytes",
                         n, exp_q.size());
                while (wb_o.cyc) begin
                    @(negedge clk_i);
                    wb_i.ack = 1'b1;
                    #1;
                end
                wb_i.ack = 1'b0;
            end else if (!req_ready_o) begin
                errors++;
                $display("entry %0d: req_ready_o did not return after the last byte", n);
            end
        end

        repeat (2) @(negedge clk_i);
        print_summary();
        if (errors == 0 && u_te_packet_emitter.u_checker.fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* project.f */
hw/te_trace_pkg.sv
hw/te_bus_pkg.sv
hw/te_payload_builder.sv
hw/te_emit_fsm.sv
hw/te_byte_counter.sv
hw/te_byte_shifter.sv
hw/te_packet_emitter.sv
bench/te_packet_emitter_checker.sv
bench/te_packet_emitter_tb.sv

/* Makefile */
# Verilator build and run for the trace packet emitter

VERILATOR ?= verilator
TOP       ?= te_packet_emitter_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
FILELIST  := project.f
SRCS      := $(shell grep -v '^+' $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: $(BIN)
	@out="$$(./$(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
